// ==== compile.f ====
src/dsp_cfg_pkg.sv
src/dsp_cmd_pkg.sv
src/sdp_ram.sv
src/env_arbiter.sv
src/pulse_proc.sv
src/dsp_top.sv
verif/dsp_assert.sv
verif/dsp_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run dsp_tb and check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module dsp_tb -Mdir obj_dir
	-./obj_dir/Vdsp_tb > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qxF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/dsp_tb.sv ====
`default_nettype none

module dsp_tb;

    localparam int prog_len = 4;
    localparam int n_tests = 7;
    localparam int run_timeout = 4000;                     // Cycles from start to all idle
    localparam int near_unity = (1 << (dsp_cfg_pkg::amp_w - 1)) - 1;
    localparam logic [1:0] fill_ramp = 2'd0;
    localparam logic [1:0] fill_random = 2'd1;
    localparam logic [1:0] fill_edge = 2'd2;                // Holds the most negative sample

    typedef logic signed [dsp_cfg_pkg::sample_w-1:0] sample_t;
    typedef logic signed [dsp_cfg_pkg::amp_w-1:0]    amp_t;
    typedef logic [dsp_cfg_pkg::env_addr_w-1:0]      env_addr_t;
    typedef logic [dsp_cfg_pkg::len_w-1:0]           len_t;
    typedef logic [dsp_cfg_pkg::delay_w-1:0]         delay_t;
    typedef logic [dsp_cfg_pkg::core_sel_w-1:0]      core_sel_t;
    typedef logic [dsp_cfg_pkg::host_addr_w-1:0]     host_addr_t;
    typedef logic [dsp_cfg_pkg::cmd_w-1:0]           word_t;

    typedef struct packed {
        logic [1:0] fill;
        logic       rand_prog;                              // Re-roll every pulse before the run
        dsp_cmd_pkg::cmd_word_u [dsp_cfg_pkg::nproc-1:0][prog_len-1:0] prog;
    } test_entry_t;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          start;
    dsp_cmd_pkg::host_write_t      host_wr;
    dsp_cmd_pkg::dac_sample_t      dac [dsp_cfg_pkg::nproc];
    logic [dsp_cfg_pkg::nproc-1:0] busy;

    test_entry_t                   tests [n_tests];
    string                         test_name [n_tests];
    string                         cur_name;
    sample_t                       env_model [2**dsp_cfg_pkg::env_addr_w];
    sample_t                       exp_q [dsp_cfg_pkg::nproc][$];
    logic [dsp_cfg_pkg::nproc-1:0] busy_prev;

    dsp_top i_dsp_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .host_wr(host_wr),
        .dac    (dac),
        .busy   (busy)
    );

    always #2 clk = ~clk;

    // ####################
    // Failure reporting and compare tasks
    task automatic fail_run();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic report_problem(string msg);
        $display("%s", msg);
        fail_run();
    endtask

    task automatic check_sample(int core, dsp_cmd_pkg::dac_sample_t expected,
                                dsp_cmd_pkg::dac_sample_t actual);
        if (actual !== expected) begin
            $display("error %s core %0d: expected valid=%b sample=%0d, actual valid=%b sample=%0d",
                     cur_name, core, expected.valid, expected.sample, actual.valid, actual.sample);
            fail_run();
        end
    endtask

    task automatic check_busy(string what, logic [dsp_cfg_pkg::nproc-1:0] expected,
                              logic [dsp_cfg_pkg::nproc-1:0] actual);
        if (actual !== expected) begin
            $display("error %s (%s): expected busy %b, actual busy %b",
                     cur_name, what, expected, actual);
            fail_run();
        end
    endtask

    // ####################
    // Command words and the scaling rule
    function automatic dsp_cmd_pkg::cmd_word_u pulse_cmd(int addr, int len, int amp);
        dsp_cmd_pkg::cmd_word_u w;
        w = '0;
        w.pulse.op = dsp_cmd_pkg::op_pulse;
        w.pulse.addr = env_addr_t'(addr);
        w.pulse.len = len_t'(len);
        w.pulse.amp = amp_t'(amp);
        return w;
    endfunction

    function automatic dsp_cmd_pkg::cmd_word_u delay_cmd(int cycles);
        dsp_cmd_pkg::cmd_word_u w;
        w = '0;
        w.delay.op = dsp_cmd_pkg::op_delay;
        w.delay.cycles = delay_t'(cycles);
        return w;
    endfunction

    function automatic dsp_cmd_pkg::cmd_word_u done_cmd();
        dsp_cmd_pkg::cmd_word_u w;
        w = '0;
        w.delay.op = dsp_cmd_pkg::op_done;
        return w;
    endfunction

    // Multiply, arithmetic shift, then clamp to the signed sample range
    function automatic sample_t scale(sample_t s, amp_t amp);
        longint prod;
        longint top;
        top = (longint'(1) <<< (dsp_cfg_pkg::sample_w - 1)) - 1;
        prod = (longint'(s) * longint'(amp)) >>> dsp_cfg_pkg::amp_shift;
        if (prod > top) begin
            prod = top;
        end else if (prod < -top - 1) begin
            prod = -top - 1;
        end
        return sample_t'(prod);
    endfunction

    // ####################
    // Test table
    task automatic set_program(int t, int c, dsp_cmd_pkg::cmd_word_u w0,
                               dsp_cmd_pkg::cmd_word_u w1, dsp_cmd_pkg::cmd_word_u w2,
                               dsp_cmd_pkg::cmd_word_u w3);
        tests[t].prog[c][0] = w0;
        tests[t].prog[c][1] = w1;
        tests[t].prog[c][2] = w2;
        tests[t].prog[c][3] = w3;
    endtask

    task automatic build_table();
        test_name[0] = "unity_core0";                       // Core 1 only holds done
        tests[0].fill = fill_ramp;
        tests[0].rand_prog = 1'b0;
        set_program(0, 0, pulse_cmd(16, 24, near_unity), done_cmd(), done_cmd(), done_cmd());
        set_program(0, 1, done_cmd(), done_cmd(), done_cmd(), done_cmd());

        test_name[1] = "signed_amp";                        // -8192 on -32768 saturates
        tests[1].fill = fill_edge;
        tests[1].rand_prog = 1'b0;
        set_program(1, 0, pulse_cmd(0, 20, -8192), pulse_cmd(500, 16, 3000),
                    pulse_cmd(1020, 10, -1234), done_cmd());
        set_program(1, 1, pulse_cmd(40, 12, -2048), done_cmd(), done_cmd(), done_cmd());

        test_name[2] = "shared_overlap";
        tests[2].fill = fill_ramp;
        tests[2].rand_prog = 1'b0;
        set_program(2, 0, pulse_cmd(100, 40, 5000), pulse_cmd(130, 20, -7000),
                    done_cmd(), done_cmd());
        set_program(2, 1, pulse_cmd(120, 40, -3000), pulse_cmd(100, 30, near_unity),
                    done_cmd(), done_cmd());

        test_name[3] = "pulse_delay_pulse";
        tests[3].fill = fill_ramp;
        tests[3].rand_prog = 1'b0;
        set_program(3, 0, pulse_cmd(300, 10, near_unity), delay_cmd(25),
                    pulse_cmd(310, 10, -4096), done_cmd());
        set_program(3, 1, delay_cmd(7), pulse_cmd(305, 8, 2000), done_cmd(), done_cmd());

        for (int t = 4; t < n_tests; t++) begin
            test_name[t] = $sformatf("random_%0d", t - 4);
            tests[t].fill = fill_random;
            tests[t].rand_prog = 1'b1;
            set_program(t, 0, pulse_cmd(0, 1, 0), delay_cmd(13), pulse_cmd(0, 1, 0), done_cmd());
            set_program(t, 1, pulse_cmd(0, 1, 0), pulse_cmd(0, 1, 0), done_cmd(), done_cmd());
        end
    endtask

    task automatic reroll_pulses(int t);
        int addr;
        int len;
        int amp;
        for (int c = 0; c < dsp_cfg_pkg::nproc; c++) begin
            for (int i = 0; i < prog_len; i++) begin
                if (tests[t].prog[c][i].pulse.op == dsp_cmd_pkg::op_pulse) begin
                    addr = int'($urandom_range(0, (1 << dsp_cfg_pkg::env_addr_w) - 1));
                    len = int'($urandom_range(1, (1 << dsp_cfg_pkg::len_w) - 1));
                    amp = int'($urandom_range(0, (1 << dsp_cfg_pkg::amp_w) - 1)) - near_unity - 1;
                    tests[t].prog[c][i] = pulse_cmd(addr, len, amp);
                end
            end
        end
    endtask

    // ####################
    // Host port and expected sequences
    task automatic host_write(dsp_cmd_pkg::mem_sel_e sel, int core, int addr, word_t data);
        dsp_cmd_pkg::host_write_t w;
        w.en = 1'b1;
        w.core_sel = core_sel_t'(core);
        w.mem_sel = sel;
        w.addr = host_addr_t'(addr);
        w.data = data;
        @(posedge clk);
        host_wr <= w;
    endtask

    task automatic fill_envelope(logic [1:0] mode);
        sample_t s;
        for (int a = 0; a < 2**dsp_cfg_pkg::env_addr_w; a++) begin
            case (mode)
                fill_ramp:   s = sample_t'(a * 61 + 7);
                fill_random: s = sample_t'($urandom);
                default:     s = sample_t'(a * 64) ^ 16'sh8000;
            endcase
            env_model[a] = s;
            host_write(dsp_cmd_pkg::sel_env, 0, a, word_t'(s));
        end
    endtask

    task automatic build_expected(int t);
        dsp_cmd_pkg::cmd_word_u w;
        logic                   stopped;
        for (int c = 0; c < dsp_cfg_pkg::nproc; c++) begin
            exp_q[c].delete();
            stopped = 1'b0;
            for (int i = 0; i < prog_len && !stopped; i++) begin
                w = tests[t].prog[c][i];
                host_write(dsp_cmd_pkg::sel_cmd, c, i, word_t'(w));
                case (w.pulse.op)
                    dsp_cmd_pkg::op_pulse: begin
                        for (int k = 0; k < int'(w.pulse.len); k++) begin
                            exp_q[c].push_back(scale(
                                env_model[env_addr_t'(int'(w.pulse.addr) + k)], w.pulse.amp));
                        end
                    end
                    dsp_cmd_pkg::op_delay: ;
                    default: stopped = 1'b1;
                endcase
            end
        end
        @(posedge clk);
        host_wr.en <= 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > run_timeout) begin
                report_problem($sformatf("%s: cores still busy after %0d cycles",
                                         cur_name, run_timeout));
            end
        end while (busy != '0);
    endtask

    task automatic run_test(int t);
        cur_name = test_name[t];
        if (tests[t].rand_prog) begin
            reroll_pulses(t);
        end
        fill_envelope(tests[t].fill);
        build_expected(t);
        @(negedge clk);
        check_busy("before start", '0, busy);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_busy("after start", '1, busy);
        wait_idle();
        for (int c = 0; c < dsp_cfg_pkg::nproc; c++) begin
            if (exp_q[c].size() != 0) begin
                report_problem($sformatf("%s: core %0d went idle with %0d samples missing",
                                         cur_name, c, exp_q[c].size()));
            end
        end
        repeat (6) begin
            @(negedge clk);
            check_busy("after done", '0, busy);
        end
    endtask

    // DAC scoreboard sampled away from the active edge
    always @(negedge clk) begin : scoreboard
        dsp_cmd_pkg::dac_sample_t want;
        if (rst_n) begin
            for (int c = 0; c < dsp_cfg_pkg::nproc; c++) begin
                if (dac[c].valid && exp_q[c].size() == 0) begin
                    report_problem($sformatf(
                        "%s: core %0d gave a DAC sample that no command asked for",
                        cur_name, c));
                end else if (dac[c].valid) begin
                    want.valid = 1'b1;
                    want.sample = exp_q[c].pop_front();
                    check_sample(c, want, dac[c]);
                end
                if (busy_prev[c] && !busy[c] && exp_q[c].size() != 0) begin
                    report_problem($sformatf("%s: core %0d dropped busy before its last sample",
                                             cur_name, c));
                end
            end
            busy_prev = busy;
        end
    end

    initial begin
        void'($urandom(32));
        rst_n = 1'b0;
        start = 1'b0;
        host_wr = '0;
        busy_prev = '0;
        cur_name = "reset";
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_busy("after reset", '0, busy);
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/dsp_assert.sv ====
`default_nettype none

module dsp_assert (
    input logic                          clk,
    input logic                          rst_n,
    input logic [dsp_cfg_pkg::nproc-1:0] grant,
    input logic                          core_grant,
    input logic                          core_req,
    input logic                          dac_valid,
    input logic                          busy
);

    // ####################
    // Arbiter side
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
        else $error("more than one envelope grant in the same cycle");

    // ####################
    // Processor side
    assert property (@(posedge clk) disable iff (!rst_n) core_grant |-> core_req)
        else $error("envelope grant given to a core that was not requesting");

    assert property (@(posedge clk) disable iff (!rst_n) dac_valid |-> busy)
        else $error("DAC sample valid while the core is not busy");

endmodule

// The unused inputs of each binding are tied so that those rules hold trivially
bind env_arbiter dsp_assert i_arb_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .grant     (grant),
    .core_grant(1'b0),
    .core_req  (1'b0),
    .dac_valid (1'b0),
    .busy      (1'b0)
);

bind pulse_proc dsp_assert i_proc_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .grant     ({dsp_cfg_pkg::nproc{1'b0}}),
    .core_grant(env_grant),
    .core_req  (env_req.valid),
    .dac_valid (dac.valid),
    .busy      (busy)
);

`default_nettype wire

// ==== src/dsp_top.sv ====
`default_nettype none

module dsp_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  dsp_cmd_pkg::host_write_t       host_wr,
    output dsp_cmd_pkg::dac_sample_t       dac [dsp_cfg_pkg::nproc],
    output logic [dsp_cfg_pkg::nproc-1:0]  busy
);

    logic [dsp_cfg_pkg::nproc-1:0]           cmd_wen;
    logic                                    env_wen;
    logic [dsp_cfg_pkg::cmd_addr_w-1:0]      cmd_addr [dsp_cfg_pkg::nproc];
    dsp_cmd_pkg::cmd_word_u                  cmd_data [dsp_cfg_pkg::nproc];
    dsp_cmd_pkg::env_req_t                   env_req [dsp_cfg_pkg::nproc];
    dsp_cmd_pkg::env_rsp_t                   env_rsp [dsp_cfg_pkg::nproc];
    logic [dsp_cfg_pkg::nproc-1:0]           env_grant;
    logic [dsp_cfg_pkg::env_addr_w-1:0]      env_addr;
    logic signed [dsp_cfg_pkg::sample_w-1:0] env_data;

    // Host write decode
    always_comb begin
        cmd_wen = '0;
        if (host_wr.en && host_wr.mem_sel == dsp_cmd_pkg::sel_cmd) begin
            cmd_wen[host_wr.core_sel] = 1'b1;
        end
    end

    assign env_wen = host_wr.en && host_wr.mem_sel == dsp_cmd_pkg::sel_env;

    // ####################
    // One command memory and one processor per core
    for (genvar i = 0; i < dsp_cfg_pkg::nproc; i++) begin : g_core
        sdp_ram #(
            .width       (dsp_cfg_pkg::cmd_w),
            .depth_w     (dsp_cfg_pkg::cmd_addr_w),
            .read_latency(dsp_cfg_pkg::cmd_read_latency)
        ) cmd_mem (
            .clk    (clk),
            .wr_en  (cmd_wen[i]),
            .wr_addr(host_wr.addr[dsp_cfg_pkg::cmd_addr_w-1:0]),
            .wr_data(host_wr.data),
            .rd_addr(cmd_addr[i]),
            .rd_data(cmd_data[i])
        );

        pulse_proc proc (
            .clk      (clk),
            .rst_n    (rst_n),
            .start    (start),
            .cmd_addr (cmd_addr[i]),
            .cmd_data (cmd_data[i]),
            .env_req  (env_req[i]),
            .env_grant(env_grant[i]),
            .env_rsp  (env_rsp[i]),
            .dac      (dac[i]),
            .busy     (busy[i])
        );
    end

    // ####################
    // Shared envelope memory, only the low bits of a host word are kept
    sdp_ram #(
        .width       (dsp_cfg_pkg::sample_w),
        .depth_w     (dsp_cfg_pkg::env_addr_w),
        .read_latency(dsp_cfg_pkg::env_read_latency)
    ) env_mem (
        .clk    (clk),
        .wr_en  (env_wen),
        .wr_addr(host_wr.addr[dsp_cfg_pkg::env_addr_w-1:0]),
        .wr_data(host_wr.data[dsp_cfg_pkg::sample_w-1:0]),
        .rd_addr(env_addr),
        .rd_data(env_data)
    );

    env_arbiter env_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (env_req),
        .grant   (env_grant),
        .ram_addr(env_addr),
        .ram_data(env_data),
        .rsp     (env_rsp)
    );

endmodule

`default_nettype wire

// ==== src/pulse_proc.sv ====
`default_nettype none

module pulse_proc (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    output logic [dsp_cfg_pkg::cmd_addr_w-1:0] cmd_addr,
    input  dsp_cmd_pkg::cmd_word_u             cmd_data,
    output dsp_cmd_pkg::env_req_t              env_req,
    input  logic                               env_grant,
    input  dsp_cmd_pkg::env_rsp_t              env_rsp,
    output dsp_cmd_pkg::dac_sample_t           dac,
    output logic                               busy
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_wait_fetch,
        st_pulse,
        st_delay,
        st_done
    } state_t;

    state_t                                     state_q;
    logic [dsp_cfg_pkg::cmd_addr_w-1:0]         pc_q;
    logic [dsp_cfg_pkg::cmd_read_latency-1:0]   fetch_q;     // Tracks the command read
    logic                                       cmd_vld;
    logic                                       is_pulse;
    logic [dsp_cfg_pkg::len_w-1:0]              req_left_q;
    logic [dsp_cfg_pkg::len_w-1:0]              rsp_left_q;
    logic [dsp_cfg_pkg::delay_w-1:0]            delay_q;
    logic [dsp_cfg_pkg::env_addr_w-1:0]         req_addr_q;
    logic signed [dsp_cfg_pkg::amp_w-1:0]       amp_q;
    logic                                       req_fire;

    logic signed [dsp_cfg_pkg::sample_w+dsp_cfg_pkg::amp_w-1:0] product;
    logic signed [dsp_cfg_pkg::sample_w+dsp_cfg_pkg::amp_w-1:0] scaled;
    logic signed [dsp_cfg_pkg::sample_w-1:0]                    sat;
    logic                                                       dac_valid_q;
    logic signed [dsp_cfg_pkg::sample_w-1:0]                    dac_sample_q;

    assign cmd_vld = (state_q == st_wait_fetch) && fetch_q[dsp_cfg_pkg::cmd_read_latency-1];
    assign is_pulse = cmd_data.pulse.op == dsp_cmd_pkg::op_pulse;
    assign cmd_addr = pc_q;
    assign env_req.valid = (state_q == st_pulse) && (req_left_q != '0);
    assign env_req.addr = req_addr_q;
    assign req_fire = env_req.valid && env_grant;
    assign busy = (state_q != st_idle) && (state_q != st_done);

    // ####################
    // Sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
            pc_q <= '0;
            fetch_q <= '0;
            req_left_q <= '0;
            rsp_left_q <= '0;
            delay_q <= '0;
        end else begin
            fetch_q[0] <= state_q == st_fetch;
            for (int s = 1; s < dsp_cfg_pkg::cmd_read_latency; s++) begin
                fetch_q[s] <= fetch_q[s-1];
            end
            case (state_q)
                st_idle, st_done: begin
                    if (start) begin
                        pc_q <= '0;
                        state_q <= st_fetch;
                    end
                end
                st_fetch: state_q <= st_wait_fetch;
                st_wait_fetch: begin
                    if (cmd_vld) begin
                        pc_q <= pc_q + 1'b1;
                        case (cmd_data.pulse.op)
                            dsp_cmd_pkg::op_pulse: begin
                                req_left_q <= cmd_data.pulse.len;
                                rsp_left_q <= cmd_data.pulse.len;
                                state_q <= st_pulse;
                            end
                            dsp_cmd_pkg::op_delay: begin
                                delay_q <= cmd_data.delay.cycles;
                                state_q <= (cmd_data.delay.cycles == '0) ? st_fetch : st_delay;
                            end
                            default: state_q <= st_done;   // op_done and unused codes
                        endcase
                    end
                end
                st_pulse: begin
                    if (req_fire) begin
                        req_left_q <= req_left_q - 1'b1;
                    end
                    if (env_rsp.valid) begin
                        rsp_left_q <= rsp_left_q - 1'b1;
                    end
                    if (rsp_left_q == '0) begin
                        state_q <= st_fetch;          // Every sample is back
                    end
                end
                st_delay: begin
                    delay_q <= delay_q - 1'b1;
                    if (delay_q == 1) begin
                        state_q <= st_fetch;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_vld && is_pulse) begin
            req_addr_q <= cmd_data.pulse.addr;
            amp_q <= cmd_data.pulse.amp;
        end else if (req_fire) begin
            req_addr_q <= req_addr_q + 1'b1;          // Stalls while not granted
        end
    end

    // ####################
    // Scale, shift and clamp to the DAC range
    always_comb begin
        product = env_rsp.sample * amp_q;
        scaled = product >>> dsp_cfg_pkg::amp_shift;
        if (&scaled[$high(scaled):dsp_cfg_pkg::sample_w-1] ||
            ~|scaled[$high(scaled):dsp_cfg_pkg::sample_w-1]) begin
            sat = scaled[dsp_cfg_pkg::sample_w-1:0];
        end else if (scaled[$high(scaled)]) begin
            sat = {1'b1, {(dsp_cfg_pkg::sample_w-1){1'b0}}};
        end else begin
            sat = {1'b0, {(dsp_cfg_pkg::sample_w-1){1'b1}}};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dac_valid_q <= 1'b0;
        end else begin
            dac_valid_q <= env_rsp.valid;
        end
    end

    always_ff @(posedge clk) begin
        dac_sample_q <= sat;
    end

    assign dac.valid = dac_valid_q;
    assign dac.sample = dac_sample_q;

endmodule

`default_nettype wire

// ==== src/env_arbiter.sv ====
`default_nettype none

module env_arbiter (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  dsp_cmd_pkg::env_req_t                   req [dsp_cfg_pkg::nproc],
    output logic [dsp_cfg_pkg::nproc-1:0]           grant,
    output logic [dsp_cfg_pkg::env_addr_w-1:0]      ram_addr,
    input  logic signed [dsp_cfg_pkg::sample_w-1:0] ram_data,
    output dsp_cmd_pkg::env_rsp_t                   rsp [dsp_cfg_pkg::nproc]
);

    logic [dsp_cfg_pkg::core_sel_w-1:0] last_q;   // Most recently granted core
    logic [dsp_cfg_pkg::core_sel_w-1:0] pick;
    logic                               found;

    // Grant tracking that runs alongside the RAM read
    logic [dsp_cfg_pkg::env_read_latency-1:0] vld_q;
    logic [dsp_cfg_pkg::core_sel_w-1:0]       idx_q [dsp_cfg_pkg::env_read_latency];

    // ####################
    // Rotating priority, search starts one past the last winner
    always_comb begin
        int cand;
        grant = '0;
        pick = last_q;
        found = 1'b0;
        for (int k = 1; k <= dsp_cfg_pkg::nproc; k++) begin
            cand = (int'(last_q) + k) % dsp_cfg_pkg::nproc;
            if (!found && req[cand].valid) begin
                found = 1'b1;
                pick = cand[dsp_cfg_pkg::core_sel_w-1:0];
            end
        end
        if (found) begin
            grant[pick] = 1'b1;
        end
    end

    assign ram_addr = req[pick].addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= dsp_cfg_pkg::last_core;     // Core 0 wins first
            vld_q <= '0;
        end else begin
            if (found) begin
                last_q <= pick;
            end
            vld_q[0] <= found;
            for (int s = 1; s < dsp_cfg_pkg::env_read_latency; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        idx_q[0] <= pick;
        for (int s = 1; s < dsp_cfg_pkg::env_read_latency; s++) begin
            idx_q[s] <= idx_q[s-1];
        end
    end

    // ####################
    // Return path, the sample goes to the core that was granted
    always_comb begin
        for (int c = 0; c < dsp_cfg_pkg::nproc; c++) begin
            rsp[c].valid = 1'b0;
            rsp[c].sample = ram_data;
        end
        rsp[idx_q[dsp_cfg_pkg::env_read_latency-1]].valid =
            vld_q[dsp_cfg_pkg::env_read_latency-1];
    end

endmodule

`default_nettype wire

// ==== src/sdp_ram.sv ====
`default_nettype none

module sdp_ram #(
    parameter int width = 32,
    parameter int depth_w = 6,
    parameter int read_latency = 1
) (
    input  logic               clk,
    input  logic               wr_en,
    input  logic [depth_w-1:0] wr_addr,
    input  logic [width-1:0]   wr_data,
    input  logic [depth_w-1:0] rd_addr,
    output logic [width-1:0]   rd_data
);

    logic [width-1:0] mem [2**depth_w];
    logic [width-1:0] rd_pipe_q [read_latency];   // Stage 0 is the array read

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read pipeline, one register per cycle of latency
    always_ff @(posedge clk) begin
        rd_pipe_q[0] <= mem[rd_addr];
        for (int s = 1; s < read_latency; s++) begin
            rd_pipe_q[s] <= rd_pipe_q[s-1];
        end
    end

    assign rd_data = rd_pipe_q[read_latency-1];

endmodule

`default_nettype wire

// ==== src/dsp_cmd_pkg.sv ====
`default_nettype none

package dsp_cmd_pkg;

    typedef enum logic [1:0] {
        op_done  = 2'd0,
        op_pulse = 2'd1,
        op_delay = 2'd2
    } opcode_e;

    // #####################
    // Command word, one of two layouts selected by the opcode
    typedef struct packed {
        opcode_e                                 op;
        logic [dsp_cfg_pkg::env_addr_w-1:0]      addr;    // First envelope sample
        logic [dsp_cfg_pkg::len_w-1:0]           len;     // Sample count
        logic signed [dsp_cfg_pkg::amp_w-1:0]    amp;
    } pulse_cmd_t;

    typedef struct packed {
        opcode_e                                 op;
        logic [dsp_cfg_pkg::delay_w-1:0]         cycles;
    } delay_cmd_t;

    typedef union packed {
        pulse_cmd_t pulse;
        delay_cmd_t delay;
    } cmd_word_u;

    // #####################
    // Host side
    typedef enum logic {
        sel_cmd = 1'b0,
        sel_env = 1'b1
    } mem_sel_e;

    typedef struct packed {
        logic                                    en;
        logic [dsp_cfg_pkg::core_sel_w-1:0]      core_sel;
        mem_sel_e                                mem_sel;
        logic [dsp_cfg_pkg::host_addr_w-1:0]     addr;
        logic [dsp_cfg_pkg::cmd_w-1:0]           data;
    } host_write_t;

    // Envelope read path and DAC output
    typedef struct packed {
        logic                                    valid;
        logic [dsp_cfg_pkg::env_addr_w-1:0]      addr;
    } env_req_t;

    typedef struct packed {
        logic                                    valid;
        logic signed [dsp_cfg_pkg::sample_w-1:0] sample;
    } env_rsp_t;

    typedef struct packed {
        logic                                    valid;
        logic signed [dsp_cfg_pkg::sample_w-1:0] sample;
    } dac_sample_t;

endpackage

`default_nettype wire

// ==== src/dsp_cfg_pkg.sv ====
`default_nettype none

package dsp_cfg_pkg;

    // #####################
    // Core count and memories
    localparam int nproc = 2;
    localparam int core_sel_w = (nproc > 1) ? $clog2(nproc) : 1;
    localparam logic [core_sel_w-1:0] last_core = core_sel_w'(nproc - 1);

    localparam int cmd_addr_w = 6;                // 64 commands per core
    localparam int env_addr_w = 10;               // Shared envelope memory
    localparam int host_addr_w = (env_addr_w > cmd_addr_w) ? env_addr_w : cmd_addr_w;

    // #####################
    // Word widths
    localparam int cmd_w = 32;
    localparam int sample_w = 16;
    localparam int amp_w = 14;
    localparam int len_w = 6;
    localparam int delay_w = cmd_w - 2;           // Everything above the opcode
    localparam int amp_shift = 13;                // 8192 is unity gain

    // Read latency of each memory in clock cycles
    localparam int cmd_read_latency = 2;
    localparam int env_read_latency = 1;

endpackage

`default_nettype wire
